/* src/sram_ctrl_pkg.sv */
// Shared sizes and widths for the MCU SRAM controller, referenced by scoped name from each module
package sram_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // SRAM geometry
    ////////////////////////////////////////////////////////////

    // Widest computed execution region end, (0xFFFF + 1) << 12 sets bit 28
    localparam int REGION_END_W = 29;

    // Total SRAM size
    localparam int SRAM_SIZE_KB = 16;
    localparam logic [REGION_END_W-1:0] SRAM_SIZE_BYTES = REGION_END_W'(SRAM_SIZE_KB * 1024);

    // Byte address bits that cover the SRAM
    localparam int BYTE_ADDR_W = 14;
    // Word address bits, one word is four bytes
    localparam int WORD_ADDR_W = 12;

    ////////////////////////////////////////////////////////////
    // Data and ECC word
    ////////////////////////////////////////////////////////////

    localparam int DATA_W = 32;
    localparam int STRB_W = 4;
    // Six Hamming check bits plus overall parity
    localparam int ECC_W = 7;
    // Stored word is {ecc, data}
    localparam int CODE_W = 39;

    ////////////////////////////////////////////////////////////
    // Execution region
    ////////////////////////////////////////////////////////////

    // Size input counts 4 KB granules, 0 means one granule
    localparam int REGION_SIZE_W = 16;
    localparam int GRANULE_SHIFT = 12;

endpackage

/* src/region_filter.sv */
// Maps a request address to the execution or protected region and decides the access grant
`timescale 1ns/1ps

module region_filter (
    input  logic                                   clk,
    input  logic                                   rst_b,
    input  logic [sram_ctrl_pkg::REGION_SIZE_W-1:0] exec_region_size,
    input  logic                                   exec_lock,
    input  logic                                   mcu_rst_b,
    input  logic [sram_ctrl_pkg::BYTE_ADDR_W-1:0]  addr,
    input  logic                                   debug_req,
    input  logic                                   mcu_lsu_req,
    input  logic                                   mcu_ifu_req,
    input  logic                                   cptra_req,
    output logic                                   grant
);

    // Region end arithmetic
    logic [sram_ctrl_pkg::REGION_END_W-1:0] size_ext;
    logic [sram_ctrl_pkg::REGION_END_W-1:0] size_bytes;
    logic [sram_ctrl_pkg::REGION_END_W-1:0] end_calc;
    logic [sram_ctrl_pkg::REGION_END_W-1:0] region_end;
    logic                                   overflow;
    logic                                   in_exec;

    // Execution region currently handed to the MCU
    logic mcu_owns_exec;

    ////////////////////////////////////////////////////////////
    // Region mapping
    ////////////////////////////////////////////////////////////

    // Zero extend before adding one so a size of 0xFFFF does not wrap
    assign size_ext   = {{(sram_ctrl_pkg::REGION_END_W - sram_ctrl_pkg::REGION_SIZE_W){1'b0}},
                         exec_region_size};
    assign size_bytes = (size_ext + 1'b1) << sram_ctrl_pkg::GRANULE_SHIFT;
    assign end_calc   = size_bytes - 1'b1;

    // Any bit beyond the SRAM scope means the region covers everything
    assign overflow   = |end_calc[sram_ctrl_pkg::REGION_END_W-1:sram_ctrl_pkg::BYTE_ADDR_W];
    assign region_end = overflow ? (sram_ctrl_pkg::SRAM_SIZE_BYTES - 1'b1) : end_calc;

    // Region base is always zero
    assign in_exec = (addr <= region_end[sram_ctrl_pkg::BYTE_ADDR_W-1:0]);

    ////////////////////////////////////////////////////////////
    // Execution region ownership
    ////////////////////////////////////////////////////////////

    // Lock hands the region to the MCU at once
    // Clearing the lock is not enough, the MCU may still fetch from it
    // Ownership only returns once the MCU is held in reset
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            mcu_owns_exec <= 1'b0;
        end else if (exec_lock) begin
            mcu_owns_exec <= 1'b1;
        end else if (!mcu_rst_b) begin
            mcu_owns_exec <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Privilege decision
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (!in_exec) begin
            // Protected region, MCU data side and debug only
            grant = mcu_lsu_req | debug_req;
        end else if (mcu_owns_exec) begin
            grant = mcu_lsu_req | mcu_ifu_req | debug_req;
        end else begin
            grant = cptra_req | debug_req;
        end
    end

endmodule

/* src/sram_access_fsm.sv */
// Sequences SRAM reads, full writes and read-modify-writes and owns the response handshake
`timescale 1ns/1ps

module sram_access_fsm (
    input  logic                                  clk,
    input  logic                                  rst_b,
    input  logic                                  req_valid,
    input  logic                                  req_write,
    input  logic [sram_ctrl_pkg::STRB_W-1:0]      req_wstrb,
    input  logic [sram_ctrl_pkg::BYTE_ADDR_W-1:0] req_addr,
    input  logic                                  grant,
    input  logic                                  resp_ready,
    input  logic [sram_ctrl_pkg::DATA_W-1:0]      dec_data,
    input  logic                                  double_err,
    output logic                                  req_ready,
    output logic                                  sram_cs,
    output logic                                  sram_we,
    output logic [sram_ctrl_pkg::WORD_ADDR_W-1:0] sram_addr,
    output logic                                  merge_sel,
    output logic                                  resp_valid,
    output logic [sram_ctrl_pkg::DATA_W-1:0]      resp_rdata,
    output logic                                  resp_error
);

    // One flop per non-idle state, IDLE when none is set
    logic st_read_wait;
    logic st_rmw_write;
    logic st_resp;
    logic st_idle;

    logic accept;
    logic issue;
    logic full_write;
    logic rmw_commit;
    logic [sram_ctrl_pkg::WORD_ADDR_W-1:0] addr_q;

    assign st_idle    = ~(st_read_wait | st_rmw_write | st_resp);
    assign req_ready  = st_idle;
    assign accept     = req_valid & st_idle;
    assign issue      = accept & grant;
    assign full_write = req_write & (&req_wstrb);
    // Skip the write half when the read half hit a double error
    assign rmw_commit = st_rmw_write & ~double_err;

    ////////////////////////////////////////////////////////////
    // SRAM command
    ////////////////////////////////////////////////////////////

    // First command goes out in the acceptance cycle
    assign sram_cs   = issue | rmw_commit;
    assign sram_we   = (issue & full_write) | rmw_commit;
    assign sram_addr = st_rmw_write ? addr_q : req_addr[sram_ctrl_pkg::BYTE_ADDR_W-1:2];
    assign merge_sel = st_rmw_write;

    ////////////////////////////////////////////////////////////
    // State
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            st_read_wait <= 1'b0;
            st_rmw_write <= 1'b0;
            st_resp      <= 1'b0;
        end else begin
            st_read_wait <= issue & ~req_write;
            st_rmw_write <= issue & req_write & ~full_write;
            // Denials and full writes respond right away, data phases one cycle later
            st_resp      <= (accept & (~grant | full_write)) | st_read_wait | st_rmw_write |
                            (st_resp & ~resp_ready);
        end
    end

    assign resp_valid = st_resp;

    // Response payload and held word address
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q     <= req_addr[sram_ctrl_pkg::BYTE_ADDR_W-1:2];
            resp_rdata <= '0;
            resp_error <= ~grant;
        end else if (st_read_wait) begin
            resp_rdata <= dec_data;
            resp_error <= double_err;
        end else if (st_rmw_write) begin
            resp_error <= double_err;
        end
    end

    // Never more than one busy state at a time
    a_state_onehot: assert property (@(posedge clk) disable iff (!rst_b)
        $onehot0({st_read_wait, st_rmw_write, st_resp}));

    // Back-pressured response stays put
    a_resp_hold: assert property (@(posedge clk) disable iff (!rst_b)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata) && $stable(resp_error));

endmodule

/* src/ecc_encoder.sv */
// SEC-DED encoder producing the seven stored check bits for a 32-bit write word
`timescale 1ns/1ps

module ecc_encoder (
    input  logic [sram_ctrl_pkg::DATA_W-1:0] data,
    output logic [sram_ctrl_pkg::ECC_W-1:0]  ecc
);

    // Data bits fill Hamming positions 1..38 that are not powers of two
    // Check bit k covers every position with bit k set
    always_comb begin
        int d;
        ecc = '0;
        d   = 0;
        for (int pos = 1; pos < sram_ctrl_pkg::CODE_W; pos++) begin
            // Power-of-two positions hold check bits
            if ((pos & (pos - 1)) != 0) begin
                for (int k = 0; k < sram_ctrl_pkg::ECC_W - 1; k++) begin
                    if (((pos >> k) & 1) == 1) begin
                        ecc[k] = ecc[k] ^ data[d];
                    end
                end
                d++;
            end
        end
        // Overall parity over data and Hamming bits, position 39
        ecc[sram_ctrl_pkg::ECC_W-1] = ^{ecc[sram_ctrl_pkg::ECC_W-2:0], data};
    end

endmodule

/* src/ecc_decoder.sv */
// SEC-DED decoder that corrects single-bit errors and flags double errors on SRAM read data
`timescale 1ns/1ps

module ecc_decoder (
    input  logic                             clk,
    input  logic                             rst_b,
    input  logic                             en,
    input  logic [sram_ctrl_pkg::CODE_W-1:0] code,
    output logic [sram_ctrl_pkg::DATA_W-1:0] data,
    output logic                             single_err,
    output logic                             double_err
);

    // Codeword laid out by Hamming position
    logic [sram_ctrl_pkg::CODE_W-1:1] cw;
    logic [sram_ctrl_pkg::ECC_W-2:0]  syndrome;
    logic                             parity;
    logic                             in_range;
    logic                             correctable;

    ////////////////////////////////////////////////////////////
    // Syndrome
    ////////////////////////////////////////////////////////////

    always_comb begin
        int d;
        int c;
        d        = 0;
        c        = 0;
        cw       = '0;
        syndrome = '0;
        // Scatter stored {ecc, data} back onto positions
        for (int pos = 1; pos < sram_ctrl_pkg::CODE_W; pos++) begin
            if ((pos & (pos - 1)) == 0) begin
                cw[pos] = code[sram_ctrl_pkg::DATA_W + c];
                c++;
            end else begin
                cw[pos] = code[d];
                d++;
            end
        end
        for (int pos = 1; pos < sram_ctrl_pkg::CODE_W; pos++) begin
            for (int k = 0; k < sram_ctrl_pkg::ECC_W - 1; k++) begin
                if (((pos >> k) & 1) == 1) begin
                    syndrome[k] = syndrome[k] ^ cw[pos];
                end
            end
        end
    end

    // Odd overall parity means an odd number of flipped bits
    assign parity      = ^code;
    // Syndrome beyond position 38 cannot point at a real bit
    assign in_range    = int'(syndrome) < sram_ctrl_pkg::CODE_W;
    assign correctable = parity & in_range;

    ////////////////////////////////////////////////////////////
    // Correction
    ////////////////////////////////////////////////////////////

    // Zero syndrome with odd parity is the parity bit itself, data is clean
    always_comb begin
        int d;
        d    = 0;
        data = '0;
        for (int pos = 1; pos < sram_ctrl_pkg::CODE_W; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                data[d] = cw[pos] ^ (correctable && (pos == int'(syndrome)));
                d++;
            end
        end
    end

    // Flags only count in the cycle the SRAM returns data
    assign single_err = en & correctable;
    assign double_err = en & (((|syndrome) & ~parity) | (parity & ~in_range));

    // Error flags are one-cycle pulses, reads never decode back to back
    a_err_pulse: assert property (@(posedge clk) disable iff (!rst_b)
        (single_err || double_err) |=> !(single_err || double_err));

endmodule

/* src/mcu_sram_ctrl.sv */
// Top of the MCU SRAM controller, joining region check, access FSM, ECC and the SRAM port
`timescale 1ns/1ps

module mcu_sram_ctrl (
    input  logic                                    clk,
    input  logic                                    rst_b,
    input  logic                                    mcu_rst_b,
    input  logic [sram_ctrl_pkg::REGION_SIZE_W-1:0] exec_region_size,
    input  logic                                    exec_lock,
    // Request
    input  logic                                    req_valid,
    output logic                                    req_ready,
    input  logic [sram_ctrl_pkg::BYTE_ADDR_W-1:0]   req_addr,
    input  logic                                    req_write,
    input  logic [sram_ctrl_pkg::STRB_W-1:0]        req_wstrb,
    input  logic [sram_ctrl_pkg::DATA_W-1:0]        req_wdata,
    input  logic                                    debug_req,
    input  logic                                    mcu_lsu_req,
    input  logic                                    mcu_ifu_req,
    input  logic                                    cptra_req,
    // Response
    output logic                                    resp_valid,
    input  logic                                    resp_ready,
    output logic [sram_ctrl_pkg::DATA_W-1:0]        resp_rdata,
    output logic                                    resp_error,
    // SRAM port
    output logic                                    sram_cs,
    output logic                                    sram_we,
    output logic [sram_ctrl_pkg::WORD_ADDR_W-1:0]   sram_addr,
    output logic [sram_ctrl_pkg::CODE_W-1:0]        sram_wdata,
    input  logic [sram_ctrl_pkg::CODE_W-1:0]        sram_rdata,
    // ECC status pulses
    output logic                                    sram_single_ecc_error,
    output logic                                    sram_double_ecc_error
);

    logic                               grant;
    logic                               merge_sel;
    logic                               rd_pending;
    logic                               single_err;
    logic                               double_err;
    logic [sram_ctrl_pkg::DATA_W-1:0]   dec_data;
    logic [sram_ctrl_pkg::DATA_W-1:0]   merged;
    logic [sram_ctrl_pkg::DATA_W-1:0]   wr_word;
    logic [sram_ctrl_pkg::ECC_W-1:0]    wr_ecc;
    // Write payload held past acceptance for the RMW write half
    logic [sram_ctrl_pkg::DATA_W-1:0]   wdata_q;
    logic [sram_ctrl_pkg::STRB_W-1:0]   wstrb_q;

    region_filter u_region_filter (
        .clk, .rst_b, .exec_region_size, .exec_lock, .mcu_rst_b,
        .addr (req_addr),
        .debug_req, .mcu_lsu_req, .mcu_ifu_req, .cptra_req,
        .grant
    );

    sram_access_fsm u_fsm (
        .clk, .rst_b, .req_valid, .req_write, .req_wstrb, .req_addr, .grant, .resp_ready,
        .dec_data, .double_err,
        .req_ready, .sram_cs, .sram_we, .sram_addr, .merge_sel,
        .resp_valid, .resp_rdata, .resp_error
    );

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            wdata_q <= req_wdata;
            wstrb_q <= req_wstrb;
        end
    end

    // A read went out last cycle, so sram_rdata is live now
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= sram_cs & ~sram_we;
        end
    end

    ////////////////////////////////////////////////////////////
    // Strobe merge and write word
    ////////////////////////////////////////////////////////////

    // New strobed bytes over corrected old bytes
    for (genvar i = 0; i < sram_ctrl_pkg::STRB_W; i++) begin : g_merge
        assign merged[i*8 +: 8] = wstrb_q[i] ? wdata_q[i*8 +: 8] : dec_data[i*8 +: 8];
    end

    // Full writes take the live request word
    assign wr_word    = merge_sel ? merged : req_wdata;
    assign sram_wdata = {wr_ecc, wr_word};

    ecc_encoder u_ecc_enc (
        .data (wr_word),
        .ecc  (wr_ecc)
    );

    ecc_decoder u_ecc_dec (
        .clk, .rst_b,
        .en         (rd_pending),
        .code       (sram_rdata),
        .data       (dec_data),
        .single_err (single_err),
        .double_err (double_err)
    );

    assign sram_single_ecc_error = single_err;
    assign sram_double_ecc_error = double_err;

endmodule

/* test/sram_model.sv */
// Behavioral single-port 39-bit SRAM for the controller testbench, with a bit-flip port for ECC faults
`timescale 1ns/1ps

module sram_model (
    input  logic                                  clk,
    input  logic                                  cs,
    input  logic                                  we,
    input  logic [sram_ctrl_pkg::WORD_ADDR_W-1:0] addr,
    input  logic [sram_ctrl_pkg::CODE_W-1:0]      wdata,
    output logic [sram_ctrl_pkg::CODE_W-1:0]      rdata,
    // Fault injection, XORs a mask into one stored word
    input  logic                                  flip_en,
    input  logic [sram_ctrl_pkg::WORD_ADDR_W-1:0] flip_addr,
    input  logic [sram_ctrl_pkg::CODE_W-1:0]      flip_mask
);

    logic [sram_ctrl_pkg::CODE_W-1:0] mem [0:(1 << sram_ctrl_pkg::WORD_ADDR_W)-1];

    // Read data shows up one cycle after the select, held otherwise
    always @(posedge clk) begin
        if (cs && we) begin
            mem[addr] <= wdata;
        end else if (cs) begin
            rdata <= mem[addr];
        end
        // Testbench only flips while the port is idle
        if (flip_en) begin
            mem[flip_addr] <= mem[flip_addr] ^ flip_mask;
        end
    end

endmodule

/* test/tb_mcu_sram_ctrl.sv */
// Table-driven testbench for the MCU SRAM controller, runs directed rows then random stalled traffic
`timescale 1ns/1ps

module tb_mcu_sram_ctrl;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int TABLE_LEN    = 22;
    localparam int RAND_WORDS   = 8;
    localparam int RAND_OPS     = 40;
    // Budget of 20 cycles per access
    localparam int WATCHDOG_CYCLES = (TABLE_LEN + RAND_WORDS + RAND_OPS) * 20 + RESET_CYCLES;

    // Privilege flags as {debug, lsu, ifu, cptra}
    localparam logic [3:0] LSU = 4'b0100;
    localparam logic [3:0] IFU = 4'b0010;
    localparam logic [3:0] CPT = 4'b0001;

    // Random traffic stays in the protected region, clear of the directed words
    localparam logic [13:0] RAND_BASE = 14'h1800;

    typedef struct packed {
        logic [15:0] region_size;
        logic        lock;
        logic        mrst;
        logic [3:0]  flags;
        logic [13:0] addr;
        logic        write;
        logic [3:0]  strb;
        logic [31:0] wdata;
        logic [38:0] flip;
        logic        err;
        logic [1:0]  ecc;
        logic [31:0] rdata;
        logic [1:0]  lat;
    } row_t;

    row_t rows [$];

    logic        clk;
    logic        rst_b;
    logic        mcu_rst_b;
    logic [15:0] exec_region_size;
    logic        exec_lock;
    logic        req_valid;
    logic        req_ready;
    logic [13:0] req_addr;
    logic        req_write;
    logic [3:0]  req_wstrb;
    logic [31:0] req_wdata;
    logic        debug_req;
    logic        mcu_lsu_req;
    logic        mcu_ifu_req;
    logic        cptra_req;
    logic        resp_valid;
    logic        resp_ready;
    logic [31:0] resp_rdata;
    logic        resp_error;
    logic        sram_cs;
    logic        sram_we;
    logic [11:0] sram_addr;
    logic [38:0] sram_wdata;
    logic [38:0] sram_rdata;
    logic        sram_single_ecc_error;
    logic        sram_double_ecc_error;
    logic        flip_en;
    logic [11:0] flip_addr;
    logic [38:0] flip_mask;

    int errors = 0;
    int checks = 0;
    int seed   = 25468;

    mcu_sram_ctrl DUT (.*);

    sram_model u_sram (
        .clk, .cs (sram_cs), .we (sram_we), .addr (sram_addr),
        .wdata (sram_wdata), .rdata (sram_rdata),
        .flip_en, .flip_addr, .flip_mask
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns: %s (got %0h, expected %0h)", $time, what, got, exp);
        end
    endtask

    function automatic void add_row(
        input logic [15:0] region_size, input logic lock, input logic mrst,
        input logic [3:0] flags, input logic [13:0] addr, input logic write,
        input logic [3:0] strb, input logic [31:0] wdata, input logic [38:0] flip,
        input logic err, input logic [1:0] ecc, input logic [31:0] rdata,
        input logic [1:0] lat
    );
        rows.push_back('{region_size, lock, mrst, flags, addr, write, strb, wdata, flip,
                         err, ecc, rdata, lat});
    endfunction

    // Called at edge+1, lock, reset and fault take effect on the next edge
    task automatic set_controls(input logic [15:0] region_size, input logic lock,
                                input logic mrst, input logic [13:0] addr,
                                input logic [38:0] flip);
        exec_region_size = region_size;
        exec_lock        = lock;
        mcu_rst_b        = mrst;
        flip_en          = |flip;
        flip_addr        = addr[13:2];
        flip_mask        = flip;
        @(posedge clk);
        #1;
        flip_en = 1'b0;
    endtask

    // One request through both handshakes, latency counted from the acceptance edge
    task automatic run_access(
        input  logic [3:0]  flags,
        input  logic [13:0] addr,
        input  logic        write,
        input  logic [3:0]  strb,
        input  logic [31:0] wdata,
        input  logic        granted,
        input  logic        stall,
        output logic [31:0] rdata,
        output logic        err,
        output int          lat,
        output logic        saw_single,
        output logic        saw_double
    );
        int   cycles;
        int   r;
        logic seen;
        logic done;
        {debug_req, mcu_lsu_req, mcu_ifu_req, cptra_req} = flags;
        req_addr  = addr;
        req_write = write;
        req_wstrb = strb;
        req_wdata = wdata;
        req_valid = 1'b1;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        // First SRAM command goes out in the acceptance cycle, none on a denial
        if (granted) begin
            check({sram_cs, sram_we}, {1'b1, write && strb == 4'hF}, "SRAM command at acceptance");
            check(sram_addr, addr[13:2], "SRAM word address");
            if (write && strb == 4'hF) begin
                check(sram_wdata[31:0], wdata, "SRAM write data");
            end
        end else begin
            check(sram_cs, 1'b0, "SRAM access on a denied request");
        end
        @(posedge clk);
        #1;
        req_valid  = 1'b0;
        cycles     = 0;
        seen       = 1'b0;
        done       = 1'b0;
        lat        = 0;
        rdata      = '0;
        err        = 1'b0;
        saw_single = 1'b0;
        saw_double = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            saw_single |= sram_single_ecc_error;
            saw_double |= sram_double_ecc_error;
            // Only one request in flight
            check(req_ready, 1'b0, "req_ready while busy");
            if (resp_valid) begin
                if (!seen) begin
                    seen  = 1'b1;
                    lat   = cycles;
                    rdata = resp_rdata;
                    err   = resp_error;
                end
                check(resp_rdata, rdata, "resp_rdata held under stall");
                check(resp_error, err, "resp_error held under stall");
                done = resp_ready;
            end
            @(posedge clk);
            #1;
            if (stall) begin
                r          = $random(seed);
                resp_ready = r[0];
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed table
    ////////////////////////////////////////////////////////////

    // Columns: size, lock, mcu_rst_b, flags, addr, write, strb, wdata,
    // flip mask, error, ecc pulse (1 single, 2 double), rdata, latency
    function automatic void build_table();
        // Full write, read back, then a partial merge of bytes 0 and 2
        add_row(16'h0, 0, 1, LSU, 14'h1000, 1, 4'hF, 32'hA5A5_1234, 0, 0, 0, 32'h0, 1);
        add_row(16'h0, 0, 1, LSU, 14'h1000, 0, 4'h0, 32'h0, 0, 0, 0, 32'hA5A5_1234, 2);
        add_row(16'h0, 0, 1, LSU, 14'h1000, 1, 4'h5, 32'h1122_3344, 0, 0, 0, 32'h0, 2);
        add_row(16'h0, 0, 1, LSU, 14'h1000, 0, 4'h0, 32'h0, 0, 0, 0, 32'hA522_1244, 2);
        // Protected region turns cptra away and keeps the word
        add_row(16'h0, 0, 1, LSU, 14'h2000, 1, 4'hF, 32'hCAFE_F00D, 0, 0, 0, 32'h0, 1);
        add_row(16'h0, 0, 1, CPT, 14'h2000, 1, 4'hF, 32'hDEAD_BEEF, 0, 1, 0, 32'h0, 1);
        add_row(16'h0, 0, 1, CPT, 14'h2000, 0, 4'h0, 32'h0, 0, 1, 0, 32'h0, 1);
        add_row(16'h0, 0, 1, LSU, 14'h2000, 0, 4'h0, 32'h0, 0, 0, 0, 32'hCAFE_F00D, 2);
        // Oversized size clamps to the whole SRAM
        add_row(16'h0004, 0, 1, CPT, 14'h2000, 0, 4'h0, 32'h0, 0, 0, 0, 32'hCAFE_F00D, 2);
        add_row(16'hFFFF, 0, 1, CPT, 14'h2004, 1, 4'hF, 32'h0BAD_CAFE, 0, 0, 0, 32'h0, 1);
        // Ownership handover in the 4 KB execution region
        add_row(16'h0, 0, 1, CPT, 14'h0040, 1, 4'hF, 32'h1357_9BDF, 0, 0, 0, 32'h0, 1);
        add_row(16'h0, 1, 1, CPT, 14'h0040, 0, 4'h0, 32'h0, 0, 1, 0, 32'h0, 1);
        add_row(16'h0, 1, 1, IFU, 14'h0040, 0, 4'h0, 32'h0, 0, 0, 0, 32'h1357_9BDF, 2);
        add_row(16'h0, 0, 1, IFU, 14'h0040, 0, 4'h0, 32'h0, 0, 0, 0, 32'h1357_9BDF, 2);
        add_row(16'h0, 0, 1, CPT, 14'h0040, 0, 4'h0, 32'h0, 0, 1, 0, 32'h0, 1);
        add_row(16'h0, 0, 0, CPT, 14'h0040, 0, 4'h0, 32'h0, 0, 0, 0, 32'h1357_9BDF, 2);
        // ECC, single flip corrected, double flip reported, RMW write skipped
        add_row(16'h0, 0, 1, LSU, 14'h3000, 1, 4'hF, 32'h600D_D00D, 0, 0, 0, 32'h0, 1);
        add_row(16'h0, 0, 1, LSU, 14'h3000, 0, 4'h0, 32'h0, 39'h20, 0, 1, 32'h600D_D00D, 2);
        add_row(16'h0, 0, 1, LSU, 14'h3004, 1, 4'hF, 32'h0F0F_0F0F, 0, 0, 0, 32'h0, 1);
        add_row(16'h0, 0, 1, LSU, 14'h3004, 0, 4'h0, 32'h0, 39'h3, 1, 2, 32'h0, 2);
        add_row(16'h0, 0, 1, LSU, 14'h3004, 1, 4'h1, 32'hFF, 0, 1, 2, 32'h0, 2);
        add_row(16'h0, 0, 1, LSU, 14'h3004, 0, 4'h0, 32'h0, 0, 1, 2, 32'h0, 2);
    endfunction

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        row_t        row;
        logic [31:0] ref_mem [RAND_WORDS];
        logic [31:0] got_rdata;
        logic [31:0] wd;
        logic [3:0]  strb;
        logic [2:0]  idx;
        logic        wr;
        logic        got_err;
        logic        saw_single;
        logic        saw_double;
        int          got_lat;
        int          tmp;
        int          i;
        int          b;
        rst_b            = 1'b0;
        mcu_rst_b        = 1'b1;
        exec_region_size = '0;
        exec_lock        = 1'b0;
        req_valid        = 1'b0;
        req_addr         = '0;
        req_write        = 1'b0;
        req_wstrb        = '0;
        req_wdata        = '0;
        debug_req        = 1'b0;
        mcu_lsu_req      = 1'b0;
        mcu_ifu_req      = 1'b0;
        cptra_req        = 1'b0;
        resp_ready       = 1'b1;
        flip_en          = 1'b0;
        flip_addr        = '0;
        flip_mask        = '0;
        build_table();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_b = 1'b1;
        @(negedge clk);
        check(resp_valid, 1'b0, "resp_valid after reset");
        check(req_ready, 1'b1, "req_ready after reset");
        check({sram_cs, sram_we}, 2'b00, "SRAM idle after reset");
        check({sram_single_ecc_error, sram_double_ecc_error}, 2'b00, "ECC pulses after reset");
        @(posedge clk);
        #1;

        for (i = 0; i < rows.size(); i++) begin
            row = rows[i];
            set_controls(row.region_size, row.lock, row.mrst, row.addr, row.flip);
            // An error without an ECC pulse is a privilege denial
            run_access(row.flags, row.addr, row.write, row.strb, row.wdata,
                       !(row.err && row.ecc == 2'd0), 1'b0,
                       got_rdata, got_err, got_lat, saw_single, saw_double);
            check(got_err, row.err, $sformatf("row %0d resp_error", i));
            check(got_lat, row.lat, $sformatf("row %0d latency", i));
            check(saw_single, row.ecc == 2'd1, $sformatf("row %0d single ECC pulse", i));
            check(saw_double, row.ecc == 2'd2, $sformatf("row %0d double ECC pulse", i));
            if (!row.write && !row.err) begin
                check(got_rdata, row.rdata, $sformatf("row %0d resp_rdata", i));
            end
        end

        // Random traffic with resp_ready stalls against a reference memory
        set_controls(16'h0, 1'b0, 1'b1, RAND_BASE, 39'h0);
        for (i = 0; i < RAND_WORDS; i++) begin
            tmp = $random(seed);
            wd  = tmp;
            run_access(LSU, RAND_BASE + 14'(i * 4), 1'b1, 4'hF, wd, 1'b1, 1'b1,
                       got_rdata, got_err, got_lat, saw_single, saw_double);
            check(got_err, 1'b0, $sformatf("fill word %0d error", i));
            ref_mem[i] = wd;
        end
        for (i = 0; i < RAND_OPS; i++) begin
            tmp  = $random(seed);
            idx  = tmp[2:0];
            wr   = tmp[3];
            strb = tmp[7:4];
            tmp  = $random(seed);
            wd   = tmp;
            run_access(LSU, RAND_BASE + {9'h0, idx, 2'b00}, wr, strb, wd, 1'b1, 1'b1,
                       got_rdata, got_err, got_lat, saw_single, saw_double);
            check(got_err, 1'b0, $sformatf("random op %0d error", i));
            if (wr) begin
                // Strobed bytes replace the old ones
                for (b = 0; b < 4; b++) begin
                    if (strb[b]) begin
                        ref_mem[idx][b*8 +: 8] = wd[b*8 +: 8];
                    end
                end
            end else begin
                check(got_rdata, ref_mem[idx], $sformatf("random op %0d rdata", i));
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

/* sources.f */
src/sram_ctrl_pkg.sv
src/region_filter.sv
src/sram_access_fsm.sv
src/ecc_encoder.sv
src/ecc_decoder.sv
src/mcu_sram_ctrl.sv
test/sram_model.sv
test/tb_mcu_sram_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build the controller testbench with Verilator, run it and look for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_mcu_sram_ctrl

out=$(./obj_dir/Vtb_mcu_sram_ctrl)
echo "$out"
echo "$out" | grep -q "All tests passed!"
